// ==== sim.f ====
+incdir+.
rename_pkg.sv
rn_line_if.sv
rn_slot_writer.sv
rn_map_line.sv
rn_segment_ctrl.sv
rn_top.sv
tb_clkgen.sv
tb_rn_checker.sv
tb_rn_top.sv

// ==== tb_rn_top.sv ====
`include "rename_config.svh"

module tb_rn_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_INSTR        = 400;
  localparam int TIMEOUT_CYCLES = N_INSTR * 20;

  logic clk;
  logic rst_n;

  logic                     in_vld;
  rename_pkg::op_e          in_op;
  logic [`RN_LREG_BITS-1:0] in_lsrc1;
  logic                     in_lsrc1_vld;
  logic [`RN_LREG_BITS-1:0] in_lsrc2;
  logic                     in_lsrc2_vld;
  logic [`RN_LREG_BITS-1:0] in_ldst;
  logic [`RN_PREG_BITS-1:0] in_pdest;
  logic                     done_vld;
  logic [`RN_SLOT_BITS-1:0] done_slot;
  logic [`RN_LREG_BITS-1:0] arch_lreg;

  logic                     out_vld;
  logic [`RN_SLOT_BITS-1:0] out_slot;
  logic [`RN_PREG_BITS-1:0] out_psrc1;
  logic [`RN_PREG_BITS-1:0] out_psrc2;
  logic [`RN_PREG_BITS-1:0] out_old_pdest;
  logic [`RN_PREG_BITS-1:0] out_pdest;
  logic                     credit_ret;
  logic [`RN_PREG_BITS-1:0] arch_preg;

  logic [31:0]              lfsr_q;
  int                       credits;
  int                       issued;
  int                       cycles = 0;
  logic [`RN_PREG_BITS-1:0] pdest_next;
  // slots renamed and not yet completed
  logic [`RN_SLOT_BITS-1:0] pending [$];

  tb_clkgen i_clkgen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  rn_top i_rn_top (
    .clk             (clk),
    .rst_n           (rst_n),
    .in_vld_i        (in_vld),
    .in_op_i         (in_op),
    .in_lsrc1_i      (in_lsrc1),
    .in_lsrc1_vld_i  (in_lsrc1_vld),
    .in_lsrc2_i      (in_lsrc2),
    .in_lsrc2_vld_i  (in_lsrc2_vld),
    .in_ldst_i       (in_ldst),
    .in_pdest_i      (in_pdest),
    .done_vld_i      (done_vld),
    .done_slot_i     (done_slot),
    .arch_lreg_i     (arch_lreg),
    .out_vld_o       (out_vld),
    .out_slot_o      (out_slot),
    .out_psrc1_o     (out_psrc1),
    .out_psrc2_o     (out_psrc2),
    .out_old_pdest_o (out_old_pdest),
    .out_pdest_o     (out_pdest),
    .credit_ret_o    (credit_ret),
    .arch_preg_o     (arch_preg)
  );

  tb_rn_checker i_checker (
    .clk             (clk),
    .rst_n           (rst_n),
    .in_vld_i        (in_vld),
    .in_op_i         (in_op),
    .in_lsrc1_i      (in_lsrc1),
    .in_lsrc2_i      (in_lsrc2),
    .in_ldst_i       (in_ldst),
    .in_pdest_i      (in_pdest),
    .done_vld_i      (done_vld),
    .done_slot_i     (done_slot),
    .arch_lreg_i     (arch_lreg),
    .out_vld_i       (out_vld),
    .out_slot_i      (out_slot),
    .out_psrc1_i     (out_psrc1),
    .out_psrc2_i     (out_psrc2),
    .out_old_pdest_i (out_old_pdest),
    .out_pdest_i     (out_pdest),
    .credit_ret_i    (credit_ret),
    .arch_preg_i     (arch_preg)
  );

  //////////////////////////////////////////////////
  // random bits
  //////////////////////////////////////////////////

  // galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[0];
    s  = s >> 1;
    if (fb)
      s = s ^ 32'h8020_0003;
    return s;
  endfunction

  // one lfsr step per bit handed out
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
  endtask

  // run limit
  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TB FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  initial
  begin
    logic [31:0] r;
    int          idx;
    int          value_errs;
    int          other_errs;
    logic        finished;

    lfsr_q       = 32'h7db2_83ca;
    in_vld       = 1'b0;
    in_op        = rename_pkg::OP_ALU;
    in_lsrc1     = '0;
    in_lsrc1_vld = 1'b0;
    in_lsrc2     = '0;
    in_lsrc2_vld = 1'b0;
    in_ldst      = '0;
    in_pdest     = '0;
    done_vld     = 1'b0;
    done_slot    = '0;
    arch_lreg    = '0;
    credits      = `RN_DEPTH;
    issued       = 0;
    // physical tags 0..7 hold the reset map
    pdest_next   = 5'd8;
    finished     = 1'b0;

    wait (rst_n === 1'b1);
    while (!finished)
    begin
      @(posedge clk);
      // sample the dut before any of this edge's updates land
      if (credit_ret)
        credits += `RN_HALF;
      if (out_vld)
        pending.push_back(out_slot);

      // complete one outstanding slot in random order
      take_bits(1, r);
      if (r[0] && pending.size() > 0)
      begin
        take_bits(5, r);
        idx = int'(r[4:0]) % pending.size();
        done_slot <= pending[idx];
        done_vld  <= 1'b1;
        pending.delete(idx);
      end
      else
      begin
        done_vld <= 1'b0;
      end

      // new instruction, only against a credit
      take_bits(2, r);
      if (issued < N_INSTR && credits > 0 && r[1:0] != 2'b00)
      begin
        take_bits(2, r);
        in_op <= rename_pkg::op_e'(r[1:0]);
        take_bits(3, r);
        in_lsrc1 <= r[2:0];
        take_bits(1, r);
        in_lsrc1_vld <= r[0];
        take_bits(3, r);
        in_lsrc2 <= r[2:0];
        take_bits(1, r);
        in_lsrc2_vld <= r[0];
        take_bits(3, r);
        in_ldst  <= r[2:0];
        in_pdest <= pdest_next;
        in_vld   <= 1'b1;
        pdest_next = (pdest_next == 5'd31) ? 5'd8 : pdest_next + 5'd1;
        credits--;
        issued++;
      end
      else
      begin
        in_vld <= 1'b0;
      end

      take_bits(3, r);
      arch_lreg <= r[2:0];

      // all credits home means every half has retired
      finished = (issued == N_INSTR) && (credits == `RN_DEPTH) && (pending.size() == 0);
    end

    repeat (2) @(posedge clk);
    i_checker.check_end(value_errs, other_errs);
    $display("value errors %0d, other errors %0d, total %0d",
             value_errs, other_errs, value_errs + other_errs);
    if (value_errs + other_errs == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

// ==== tb_rn_checker.sv ====
`include "rename_config.svh"

module tb_rn_checker (
  input logic                     clk,
  input logic                     rst_n,
  input logic                     in_vld_i,
  input rename_pkg::op_e          in_op_i,
  input logic [`RN_LREG_BITS-1:0] in_lsrc1_i,
  input logic [`RN_LREG_BITS-1:0] in_lsrc2_i,
  input logic [`RN_LREG_BITS-1:0] in_ldst_i,
  input logic [`RN_PREG_BITS-1:0] in_pdest_i,
  input logic                     done_vld_i,
  input logic [`RN_SLOT_BITS-1:0] done_slot_i,
  input logic [`RN_LREG_BITS-1:0] arch_lreg_i,
  input logic                     out_vld_i,
  input logic [`RN_SLOT_BITS-1:0] out_slot_i,
  input logic [`RN_PREG_BITS-1:0] out_psrc1_i,
  input logic [`RN_PREG_BITS-1:0] out_psrc2_i,
  input logic [`RN_PREG_BITS-1:0] out_old_pdest_i,
  input logic [`RN_PREG_BITS-1:0] out_pdest_i,
  input logic                     credit_ret_i,
  input logic [`RN_PREG_BITS-1:0] arch_preg_i
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MIN_RETIRES = 20;

  int val_errs = 0;
  int oth_errs = 0;

  // speculative map after the youngest accepted instruction
  rename_pkg::rn_map_t spec_map;
  // map after the last retired instruction
  rename_pkg::rn_map_t arch_map;

  // accepted and not yet retired, oldest first
  int                  q_slot [$];
  rename_pkg::rn_map_t q_map  [$];
  int                  q_acc  [$];
  // edge of completion, -1 while waiting
  int                  q_done [$];

  // renamed fields expected on the next edge
  logic                     exp_vld;
  logic [`RN_SLOT_BITS-1:0] exp_slot;
  logic [`RN_PREG_BITS-1:0] exp_psrc1;
  logic [`RN_PREG_BITS-1:0] exp_psrc2;
  logic [`RN_PREG_BITS-1:0] exp_old;
  logic [`RN_PREG_BITS-1:0] exp_pdest;

  int next_slot;
  int outstanding;
  int retires;
  int cyc;

  task automatic compare_field(input string what, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp)
    begin
      $display("Error at %0t: %s got %0d expected %0d", $time, what, got, exp);
      val_errs++;
    end
  endtask

  task automatic note_failure(input string msg);
    $display("%s, at time %0t", msg, $time);
    oth_errs++;
  endtask

  task automatic reset_model();
    spec_map    = rename_pkg::rn_map_reset();
    arch_map    = rename_pkg::rn_map_reset();
    q_slot.delete();
    q_map.delete();
    q_acc.delete();
    q_done.delete();
    exp_vld     = 1'b0;
    next_slot   = 0;
    outstanding = 0;
    retires     = 0;
    cyc         = 0;
  endtask

  //////////////////////////////////////////////////
  // model steps, all on sampled pre-edge values
  //////////////////////////////////////////////////

  // one output per accepted instruction, exactly one cycle later
  task automatic check_output();
    if (exp_vld && !out_vld_i)
      note_failure("no renamed output one cycle after an accepted instruction");
    else if (!exp_vld && out_vld_i)
      note_failure("renamed output without an accepted instruction");
    else if (exp_vld)
    begin
      compare_field("out_slot", out_slot_i, exp_slot);
      compare_field("out_psrc1", out_psrc1_i, exp_psrc1);
      compare_field("out_psrc2", out_psrc2_i, exp_psrc2);
      compare_field("out_old_pdest", out_old_pdest_i, exp_old);
      compare_field("out_pdest", out_pdest_i, exp_pdest);
    end
  endtask

  // retire edge is cyc-1, so the half must be written and done by cyc-2
  task automatic retire_half();
    if (q_slot.size() < `RN_HALF)
    begin
      note_failure("credit return with fewer than four instructions outstanding");
    end
    else
    begin
      for (int k = 0; k < `RN_HALF; k++)
      begin
        if (q_done[k] < 0 || q_done[k] > cyc - 2 || q_acc[k] > cyc - 2)
          note_failure("credit returned before the older half was written and done");
      end
      arch_map = q_map[`RN_HALF-1];
      repeat (`RN_HALF)
      begin
        void'(q_slot.pop_front());
        void'(q_map.pop_front());
        void'(q_acc.pop_front());
        void'(q_done.pop_front());
      end
      outstanding -= `RN_HALF;
      retires++;
    end
  endtask

  // completion of a slot that is not waiting changes nothing
  task automatic mark_done(input int slot);
    logic found;
    found = 1'b0;
    for (int k = 0; k < q_slot.size(); k++)
    begin
      if (!found && q_slot[k] == slot && q_done[k] < 0)
      begin
        q_done[k] = cyc;
        found     = 1'b1;
      end
    end
  endtask

  task automatic accept_instr();
    if (outstanding >= `RN_DEPTH)
      note_failure("instruction sent with no credit left");
    exp_vld   = 1'b1;
    exp_slot  = next_slot[`RN_SLOT_BITS-1:0];
    exp_psrc1 = spec_map[in_lsrc1_i];
    exp_psrc2 = spec_map[in_lsrc2_i];
    exp_old   = spec_map[in_ldst_i];
    exp_pdest = in_pdest_i;
    // stores and branches leave the map alone
    if (in_op_i == rename_pkg::OP_ALU || in_op_i == rename_pkg::OP_LOAD)
      spec_map[in_ldst_i] = in_pdest_i;
    q_slot.push_back(next_slot);
    q_map.push_back(spec_map);
    q_acc.push_back(cyc);
    q_done.push_back(-1);
    next_slot = (next_slot + 1) % `RN_DEPTH;
    outstanding++;
  endtask

  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      reset_model();
      if (out_vld_i || credit_ret_i)
        note_failure("output valid or credit return high during reset");
    end
    else
    begin
      if (cyc == 0 && (out_vld_i || credit_ret_i))
        note_failure("output valid or credit return high in the first cycle after reset");
      check_output();
      if (credit_ret_i)
        retire_half();
      // header moved on the retire edge, arch map follows it
      compare_field("arch_preg", arch_preg_i, arch_map[arch_lreg_i]);
      if (done_vld_i)
        mark_done(int'(done_slot_i));
      if (in_vld_i)
        accept_instr();
      else
        exp_vld = 1'b0;
      cyc++;
    end
  end

  task automatic check_end(output int value_errs, output int other_errs);
    if (q_slot.size() != 0)
      note_failure("instructions still in the ring at the end of the run");
    if (retires < MIN_RETIRES)
      note_failure("too few retires to wrap the ring");
    value_errs = val_errs;
    other_errs = oth_errs;
  endtask

endmodule

// ==== tb_clkgen.sv ====
module tb_clkgen (
  output logic clk_o,
  output logic rst_n_o
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RESET_CYCLES = 16;

  // 10 ns period
  initial
  begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // reset low for 16 rising edges, released on an edge like any other input
  initial
  begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

// ==== rn_top.sv ====
`include "rename_config.svh"

module rn_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     in_vld_i,
  input  rename_pkg::op_e          in_op_i,
  input  logic [`RN_LREG_BITS-1:0] in_lsrc1_i,
  input  logic                     in_lsrc1_vld_i,
  input  logic [`RN_LREG_BITS-1:0] in_lsrc2_i,
  input  logic                     in_lsrc2_vld_i,
  input  logic [`RN_LREG_BITS-1:0] in_ldst_i,
  input  logic [`RN_PREG_BITS-1:0] in_pdest_i,
  input  logic                     done_vld_i,
  input  logic [`RN_SLOT_BITS-1:0] done_slot_i,
  input  logic [`RN_LREG_BITS-1:0] arch_lreg_i,
  output logic                     out_vld_o,
  output logic [`RN_SLOT_BITS-1:0] out_slot_o,
  output logic [`RN_PREG_BITS-1:0] out_psrc1_o,
  output logic [`RN_PREG_BITS-1:0] out_psrc2_o,
  output logic [`RN_PREG_BITS-1:0] out_old_pdest_o,
  output logic [`RN_PREG_BITS-1:0] out_pdest_o,
  output logic                     credit_ret_o,
  output logic [`RN_PREG_BITS-1:0] arch_preg_o
);

  logic [`RN_SLOT_BITS-1:0] wr_ptr;

  // one bundle per ring slot
  rn_line_if line_if [`RN_DEPTH] ();

  rn_slot_writer i_writer (
    .clk            (clk),
    .rst_n          (rst_n),
    .in_vld_i       (in_vld_i),
    .in_op_i        (in_op_i),
    .in_lsrc1_i     (in_lsrc1_i),
    .in_lsrc1_vld_i (in_lsrc1_vld_i),
    .in_lsrc2_i     (in_lsrc2_i),
    .in_lsrc2_vld_i (in_lsrc2_vld_i),
    .in_ldst_i      (in_ldst_i),
    .in_pdest_i     (in_pdest_i),
    .done_vld_i     (done_vld_i),
    .done_slot_i    (done_slot_i),
    .wr_ptr_o       (wr_ptr),
    .lines_o        (line_if)
  );

  // the rename ring
  for (genvar g = 0; g < `RN_DEPTH; g++)
  begin : g_line
    rn_map_line i_line (
      .clk   (clk),
      .rst_n (rst_n),
      .ln_i  (line_if[g])
    );
  end

  rn_segment_ctrl i_seg (
    .clk             (clk),
    .rst_n           (rst_n),
    .lines_i         (line_if),
    .wr_ptr_i        (wr_ptr),
    .in_vld_i        (in_vld_i),
    .arch_lreg_i     (arch_lreg_i),
    .out_vld_o       (out_vld_o),
    .out_slot_o      (out_slot_o),
    .out_psrc1_o     (out_psrc1_o),
    .out_psrc2_o     (out_psrc2_o),
    .out_old_pdest_o (out_old_pdest_o),
    .out_pdest_o     (out_pdest_o),
    .credit_ret_o    (credit_ret_o),
    .arch_preg_o     (arch_preg_o)
  );

endmodule

// ==== rn_segment_ctrl.sv ====
`include "rename_config.svh"

module rn_segment_ctrl (
  input  logic                     clk,
  input  logic                     rst_n,
  rn_line_if.seg                   lines_i [`RN_DEPTH],
  input  logic [`RN_SLOT_BITS-1:0] wr_ptr_i,
  input  logic                     in_vld_i,
  input  logic [`RN_LREG_BITS-1:0] arch_lreg_i,
  output logic                     out_vld_o,
  output logic [`RN_SLOT_BITS-1:0] out_slot_o,
  output logic [`RN_PREG_BITS-1:0] out_psrc1_o,
  output logic [`RN_PREG_BITS-1:0] out_psrc2_o,
  output logic [`RN_PREG_BITS-1:0] out_old_pdest_o,
  output logic [`RN_PREG_BITS-1:0] out_pdest_o,
  output logic                     credit_ret_o,
  output logic [`RN_PREG_BITS-1:0] arch_preg_o
);

  rename_pkg::seg_e    seg_q;
  rename_pkg::rn_map_t top_hdr_q;
  rename_pkg::rn_map_t mid_hdr_q;
  rename_pkg::rn_map_t arch_map;

  // per line taps, pulled out so they can be indexed by wr_ptr
  rename_pkg::rn_map_t cur_map   [`RN_DEPTH];
  rename_pkg::preg_t   psrc1     [`RN_DEPTH];
  rename_pkg::preg_t   psrc2     [`RN_DEPTH];
  rename_pkg::preg_t   old_pdest [`RN_DEPTH];
  rename_pkg::preg_t   wr_pdest;
  logic [`RN_DEPTH-1:0] busy;
  logic [`RN_DEPTH-1:0] waiting;

  logic old_busy;
  logic old_wait;
  logic young_busy;
  logic ptr_young;
  logic retire;

  //////////////////////////////////////////////////
  // map ring
  //////////////////////////////////////////////////

  // every line sees the same incoming entry
  assign wr_pdest = lines_i[0].wr_entry.pdest;

  for (genvar g = 0; g < `RN_DEPTH; g++)
  begin : g_tap
    assign cur_map[g]   = lines_i[g].cur_map;
    assign psrc1[g]     = lines_i[g].psrc1;
    assign psrc2[g]     = lines_i[g].psrc2;
    assign old_pdest[g] = lines_i[g].old_pdest;
    assign busy[g]      = (lines_i[g].state != rename_pkg::LINE_EMPTY);
    assign waiting[g]   = (lines_i[g].state == rename_pkg::LINE_WAIT);

    // retire hits only the older half
    assign lines_i[g].retire = retire && ((g < `RN_HALF) == (seg_q == rename_pkg::SEG_TOP));

    // the segment bit picks which of the two links is the real start of the chain
    if (g == 0)
      assign lines_i[g].prv_map = (seg_q == rename_pkg::SEG_TOP) ? top_hdr_q
                                                                 : cur_map[`RN_DEPTH-1];
    else if (g == `RN_HALF)
      assign lines_i[g].prv_map = (seg_q == rename_pkg::SEG_TOP) ? cur_map[`RN_HALF-1]
                                                                 : mid_hdr_q;
    else
      assign lines_i[g].prv_map = cur_map[g-1];
  end

  //////////////////////////////////////////////////
  // retire condition
  //////////////////////////////////////////////////

  always_comb
  begin
    if (seg_q == rename_pkg::SEG_TOP)
    begin
      old_busy   = |busy[`RN_HALF-1:0];
      old_wait   = |waiting[`RN_HALF-1:0];
      young_busy = |busy[`RN_DEPTH-1:`RN_HALF];
      ptr_young  = (int'(wr_ptr_i) >= `RN_HALF);
    end
    else
    begin
      old_busy   = |busy[`RN_DEPTH-1:`RN_HALF];
      old_wait   = |waiting[`RN_DEPTH-1:`RN_HALF];
      young_busy = |busy[`RN_HALF-1:0];
      ptr_young  = (int'(wr_ptr_i) < `RN_HALF);
    end
  end

  // ptr out of the older half means that half is fully written
  // a full younger half wraps the pointer back, its lines stand in for the pointer then
  assign retire = old_busy && !old_wait && (ptr_young || young_busy);

  //////////////////////////////////////////////////
  // headers, segment bit, credits
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      seg_q        <= rename_pkg::SEG_TOP;
      top_hdr_q    <= rename_pkg::rn_map_reset();
      mid_hdr_q    <= rename_pkg::rn_map_reset();
      credit_ret_o <= 1'b0;
    end
    else
    begin
      credit_ret_o <= retire;
      if (retire)
      begin
        // map after the older half's last line becomes architectural
        if (seg_q == rename_pkg::SEG_TOP)
        begin
          mid_hdr_q <= cur_map[`RN_HALF-1];
          seg_q     <= rename_pkg::SEG_MID;
        end
        else
        begin
          top_hdr_q <= cur_map[`RN_DEPTH-1];
          seg_q     <= rename_pkg::SEG_TOP;
        end
      end
    end
  end

  assign arch_map    = (seg_q == rename_pkg::SEG_TOP) ? top_hdr_q : mid_hdr_q;
  assign arch_preg_o = arch_map[arch_lreg_i];

  //////////////////////////////////////////////////
  // renamed output, one cycle after the write
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      out_vld_o  <= 1'b0;
      out_slot_o <= '0;
    end
    else
    begin
      out_vld_o <= in_vld_i;
      if (in_vld_i)
      begin
        out_slot_o <= wr_ptr_i;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (in_vld_i)
    begin
      out_psrc1_o     <= psrc1[wr_ptr_i];
      out_psrc2_o     <= psrc2[wr_ptr_i];
      out_old_pdest_o <= old_pdest[wr_ptr_i];
      out_pdest_o     <= wr_pdest;
    end
  end

endmodule

// ==== rn_map_line.sv ====
module rn_map_line (
  input  logic    clk,
  input  logic    rst_n,
  rn_line_if.line ln_i
);

  rename_pkg::rn_entry_t   entry_q;
  rename_pkg::line_state_e state_q;
  // entry as seen this cycle, incoming one while being written
  rename_pkg::rn_entry_t   entry_v;
  logic                    active;

  always_ff @(posedge clk)
  begin
    if (ln_i.wr_en)
    begin
      entry_q <= ln_i.wr_entry;
    end
  end

  //////////////////////////////////////////////////
  // line state
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= rename_pkg::LINE_EMPTY;
    end
    else if (ln_i.retire)
    begin
      state_q <= rename_pkg::LINE_EMPTY;
    end
    else if (ln_i.wr_en)
    begin
      state_q <= rename_pkg::LINE_WAIT;
    end
    else if (ln_i.done_en && ln_i.done && (state_q == rename_pkg::LINE_WAIT))
    begin
      // completion of an empty or finished slot falls through here
      state_q <= rename_pkg::LINE_DONE;
    end
  end

  assign ln_i.state = state_q;

  //////////////////////////////////////////////////
  // rename against the incoming map
  //////////////////////////////////////////////////

  // bypass so the drain can capture the renamed fields on the write edge
  assign entry_v = ln_i.wr_en ? ln_i.wr_entry : entry_q;
  assign active  = ln_i.wr_en || (state_q != rename_pkg::LINE_EMPTY);

  // sources and displaced tag all come from the map before this line
  assign ln_i.psrc1     = ln_i.prv_map[entry_v.lsrc1];
  assign ln_i.psrc2     = ln_i.prv_map[entry_v.lsrc2];
  assign ln_i.old_pdest = ln_i.prv_map[entry_v.ldst];

  // outgoing map, empty lines and non-writing ops pass it on untouched
  always_comb
  begin
    ln_i.cur_map = ln_i.prv_map;
    if (active && rename_pkg::op_writes_dst(entry_v.op))
    begin
      ln_i.cur_map[entry_v.ldst] = entry_v.pdest;
    end
  end

endmodule

// ==== rn_slot_writer.sv ====
`include "rename_config.svh"

module rn_slot_writer (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     in_vld_i,
  input  rename_pkg::op_e          in_op_i,
  input  logic [`RN_LREG_BITS-1:0] in_lsrc1_i,
  input  logic                     in_lsrc1_vld_i,
  input  logic [`RN_LREG_BITS-1:0] in_lsrc2_i,
  input  logic                     in_lsrc2_vld_i,
  input  logic [`RN_LREG_BITS-1:0] in_ldst_i,
  input  logic [`RN_PREG_BITS-1:0] in_pdest_i,
  input  logic                     done_vld_i,
  input  logic [`RN_SLOT_BITS-1:0] done_slot_i,
  output logic [`RN_SLOT_BITS-1:0] wr_ptr_o,
  rn_line_if.writer                lines_o [`RN_DEPTH]
);

  rename_pkg::rn_entry_t    entry;
  logic [`RN_SLOT_BITS-1:0] wr_ptr;

  // pack the front end fields
  always_comb
  begin
    entry.op        = in_op_i;
    entry.lsrc1     = in_lsrc1_i;
    entry.lsrc1_vld = in_lsrc1_vld_i;
    entry.lsrc2     = in_lsrc2_i;
    entry.lsrc2_vld = in_lsrc2_vld_i;
    entry.ldst      = in_ldst_i;
    entry.pdest     = in_pdest_i;
  end

  //////////////////////////////////////////////////
  // write pointer
  //////////////////////////////////////////////////

  // credits guarantee the slot at wr_ptr is empty, no full check here
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
    end
    else if (in_vld_i)
    begin
      if (int'(wr_ptr) == `RN_DEPTH - 1)
      begin
        wr_ptr <= '0;
      end
      else
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  assign wr_ptr_o = wr_ptr;

  //////////////////////////////////////////////////
  // slot decode
  //////////////////////////////////////////////////

  for (genvar g = 0; g < `RN_DEPTH; g++)
  begin : g_slot
    // entry goes to every line, only the pointed one latches it
    assign lines_o[g].wr_en    = in_vld_i && (int'(wr_ptr) == g);
    assign lines_o[g].wr_entry = entry;
    assign lines_o[g].done_en  = (int'(done_slot_i) == g);
    assign lines_o[g].done     = done_vld_i;
  end

endmodule

// ==== rn_line_if.sv ====
// one bundle per rename line
// writer fills and completes the slot, segment control closes the map chain
interface rn_line_if;

  // from the writer
  logic                  wr_en;
  rename_pkg::rn_entry_t wr_entry;
  // slot select for completion
  logic                  done_en;
  // completion strobe, shared by all lines
  logic                  done;

  // from the segment control
  rename_pkg::rn_map_t   prv_map;
  logic                  retire;

  // from the line
  rename_pkg::rn_map_t     cur_map;
  rename_pkg::line_state_e state;
  rename_pkg::preg_t       psrc1;
  rename_pkg::preg_t       psrc2;
  rename_pkg::preg_t       old_pdest;

  modport writer (output wr_en, wr_entry, done_en, done);

  modport line (input  wr_en, wr_entry, done_en, done, prv_map, retire,
                output cur_map, state, psrc1, psrc2, old_pdest);

  // drain also reads wr_entry to pick up the pdest of the slot being written
  modport seg (input  wr_entry, cur_map, state, psrc1, psrc2, old_pdest,
               output prv_map, retire);

endinterface

// ==== rename_pkg.sv ====
`include "rename_config.svh"

package rename_pkg;

  // opcodes, only alu and load produce a register result
  typedef enum logic [1:0] {
    OP_ALU    = 2'd0,
    OP_LOAD   = 2'd1,
    OP_STORE  = 2'd2,
    OP_BRANCH = 2'd3
  } op_e;

  // per line life cycle: written -> waiting -> done -> emptied by retire
  typedef enum logic [1:0] {
    LINE_EMPTY = 2'd0,
    LINE_WAIT  = 2'd1,
    LINE_DONE  = 2'd2
  } line_state_e;

  // which segment header is architectural
  // top: low half is the older one, mid: high half is the older one
  typedef enum logic {
    SEG_TOP = 1'b0,
    SEG_MID = 1'b1
  } seg_e;

  typedef logic [`RN_LREG_BITS-1:0] lreg_t;
  typedef logic [`RN_PREG_BITS-1:0] preg_t;

  // decoded instruction as held by one rename line
  typedef struct packed {
    op_e   op;
    lreg_t lsrc1;
    logic  lsrc1_vld;
    lreg_t lsrc2;
    logic  lsrc2_vld;
    lreg_t ldst;
    preg_t pdest;
  } rn_entry_t;

  // logical to physical map, one tag per logical register
  typedef preg_t [`RN_LREGS-1:0] rn_map_t;

  // identity map, logical i sits in physical i
  function automatic rn_map_t rn_map_reset();
    rn_map_t m;
    for (int i = 0; i < `RN_LREGS; i++)
    begin
      m[i] = preg_t'(i);
    end
    return m;
  endfunction

  function automatic logic op_writes_dst(op_e op);
    return (op == OP_ALU) || (op == OP_LOAD);
  endfunction

endpackage

// ==== rename_config.svh ====
`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

//////////////////////////////////////////////////
// ring geometry
//////////////////////////////////////////////////

// rename lines in the ring, also the credits the sender owns after reset
`define RN_DEPTH      8
// lines per segment, also the credits handed back on each retire
`define RN_HALF       4
`define RN_SLOT_BITS  3

//////////////////////////////////////////////////
// register file sizes
//////////////////////////////////////////////////

`define RN_LREGS      8
`define RN_LREG_BITS  3
`define RN_PREG_BITS  5

`endif
